/* logic/icache_config.svh */
// Build-time sizing of the instruction cache.
// Included by the package and by every RTL file that needs a size.
// Changing the index or tag width also changes the address split in the
// controller; keep ICACHE_ADDR_W = 2 + index + tag.
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// geometry, one word per line
`define ICACHE_SETS        64
`define ICACHE_INDEX_W     6     // log2 of set count
`define ICACHE_TAG_W       6     // tag bits above the index

// datapath
`define ICACHE_WORD_W      32    // one instruction word
`define ICACHE_ADDR_W      14    // byte address bits actually decoded

// memory request channel
`define ICACHE_MEM_CREDITS 2     // slots the backing memory offers out of reset

`endif

/* logic/icache_pkg.sv */
// Shared types of the instruction cache.
// Imported by wildcard in every module header; sizes come from the config
// header, the package only names the vectors and the controller states.
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

    // address pieces
    typedef logic [`ICACHE_ADDR_W-1:0]  fetch_addr_t;   // byte address from core
    typedef logic [`ICACHE_INDEX_W-1:0] set_index_t;    // addr[7:2]
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;          // addr[13:8]

    // tag store entry, valid in the msb
    typedef logic [`ICACHE_TAG_W:0]     tag_entry_t;

    // payload
    typedef logic [`ICACHE_WORD_W-1:0]  word_t;

    // memory credits, wide enough for the reset value
    typedef logic [1:0]                 credit_cnt_t;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,           // ready for a fetch
        LOOKUP,         // store outputs valid, compare tag
        REFILL_REQ,     // waiting for a credit
        REFILL_WAIT     // request sent, waiting for the word
    } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/icache_tag_ram.sv */
// Single-port tag store of the instruction cache, flip-flop array.
// One address serves read and write; rdata is registered and valid the
// cycle after a read request. Out of reset a sweep writes an invalid entry
// into every set, one per cycle, and the port is ignored until init_done.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_tag_ram
    import icache_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire             req,
    input  wire             write,      // 1 = write, 0 = read
    input  wire set_index_t addr,
    input  wire tag_entry_t wdata,
    output tag_entry_t      rdata,
    output logic            init_done   // sweep finished, port live
);

    tag_entry_t mem [`ICACHE_SETS];
    set_index_t sweep_idx;              // set being cleared
    logic       sweep_last;
    logic       wr_en;
    set_index_t wr_addr;
    tag_entry_t wr_data;

    assign sweep_last = (sweep_idx == set_index_t'(`ICACHE_SETS - 1));

    // sweep owns the write port until done
    assign wr_en   = !init_done || (req && write);
    assign wr_addr = init_done ? addr : sweep_idx;
    assign wr_data = init_done ? wdata : '0;    // valid bit low

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sweep_idx <= '0;
            init_done <= 1'b0;
        end
        else if (!init_done)
        begin
            sweep_idx <= set_index_t'(sweep_idx + 1'b1);
            if (sweep_last)
                init_done <= 1'b1;              // high from the cycle after the last clear
        end
    end

    // array and read register, contents set by the sweep
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (init_done && req && !write)
            rdata <= mem[addr];                 // holds until next read
    end

endmodule

`default_nettype wire

/* logic/icache_data_ram.sv */
// Single-port word store of the instruction cache, flip-flop array.
// Read data is registered and appears the cycle after the request.
// Only written on a refill; a word is used only when its tag entry is valid.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_data_ram
    import icache_pkg::*;
(
    input  wire             clk,
    input  wire             req,
    input  wire             write,      // refill write
    input  wire set_index_t addr,
    input  wire word_t      wdata,
    output word_t           rdata
);

    word_t mem [`ICACHE_SETS];
    logic  rd_en;
    logic  wr_en;

    assign rd_en = req && !write;
    assign wr_en = req && write;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[addr] <= wdata;
        if (rd_en)
            rdata <= mem[addr];     // lookup word, compared tag decides use
    end

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
// Controller of the blocking direct-mapped instruction cache.
// Accepts one fetch at a time, reads tag and data stores in the accept
// cycle and checks the tag the cycle after. A hit answers right there;
// a miss sends one request on the credit channel and forwards the returned
// word to the core while writing it into both stores.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,

    // core fetch port
    input  wire              fetch_valid,
    input  wire fetch_addr_t fetch_addr,
    output logic             fetch_ready,
    output logic             rsp_valid,
    output word_t            rsp_data,

    // stores
    input  wire              init_done,
    input  wire tag_entry_t  tag_rdata,
    input  wire word_t       data_rdata,
    output logic             tag_req,
    output logic             tag_write,
    output tag_entry_t       tag_wdata,
    output set_index_t       ram_addr,      // shared by both stores
    output logic             data_req,
    output logic             data_write,
    output word_t            data_wdata,

    // backing memory
    input  wire              mem_credit,    // one slot freed
    input  wire              mem_rsp_valid,
    input  wire word_t       mem_rsp_data,
    output logic             mem_req_valid,
    output fetch_addr_t      mem_req_addr   // word aligned byte address
);

    localparam int IDX_LSB = 2;                         // byte offset within word
    localparam int TAG_LSB = IDX_LSB + `ICACHE_INDEX_W;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    fetch_addr_t addr_q;                                // accepted fetch
    credit_cnt_t credit_cnt_q;
    credit_cnt_t credit_cnt_d;
    logic        init_q;                                // init_done delayed
    logic        accept;
    logic        hit;
    set_index_t  fetch_index;
    set_index_t  req_index;
    tag_t        req_tag;
    logic        entry_valid;
    tag_t        entry_tag;

    // address split
    assign fetch_index = fetch_addr[IDX_LSB +: `ICACHE_INDEX_W];
    assign req_index   = addr_q[IDX_LSB +: `ICACHE_INDEX_W];
    assign req_tag     = addr_q[TAG_LSB +: `ICACHE_TAG_W];

    assign entry_valid = tag_rdata[`ICACHE_TAG_W];
    assign entry_tag   = tag_rdata[`ICACHE_TAG_W-1:0];
    assign hit         = entry_valid && (entry_tag == req_tag);

    assign fetch_ready = (state_q == IDLE) && init_q;   // one cycle behind init_done
    assign accept      = fetch_valid && fetch_ready;

    // refill writes are fixed, only the strobes vary
    assign tag_wdata    = {1'b1, req_tag};
    assign data_wdata   = mem_rsp_data;
    assign mem_req_addr = {req_tag, req_index, {IDX_LSB{1'b0}}};

    always_comb
    begin
        state_d       = state_q;
        rsp_valid     = 1'b0;
        rsp_data      = data_rdata;                     // hit path default
        tag_req       = 1'b0;
        tag_write     = 1'b0;
        data_req      = 1'b0;
        data_write    = 1'b0;
        ram_addr      = fetch_index;                    // read address on accept
        mem_req_valid = 1'b0;
        case (state_q)
            IDLE:
            begin
                if (accept)
                begin
                    tag_req  = 1'b1;                    // read both stores
                    data_req = 1'b1;
                    state_d  = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (hit)
                begin
                    rsp_valid = 1'b1;                   // one cycle after accept
                    state_d   = IDLE;
                end
                else
                    state_d = REFILL_REQ;
            end
            REFILL_REQ:
            begin
                // no credit, no request
                if (credit_cnt_q != '0)
                begin
                    mem_req_valid = 1'b1;
                    state_d       = REFILL_WAIT;
                end
            end
            REFILL_WAIT:
            begin
                if (mem_rsp_valid)
                begin
                    rsp_valid  = 1'b1;                  // forward in the same cycle
                    rsp_data   = mem_rsp_data;
                    tag_req    = 1'b1;
                    tag_write  = 1'b1;
                    data_req   = 1'b1;
                    data_write = 1'b1;
                    ram_addr   = req_index;
                    state_d    = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // credits: +1 per returned slot, -1 per request
    always_comb
    begin
        credit_cnt_d = credit_cnt_q;
        if (mem_credit && !mem_req_valid)
            credit_cnt_d = credit_cnt_q + credit_cnt_t'(1);
        else if (!mem_credit && mem_req_valid)
            credit_cnt_d = credit_cnt_q - credit_cnt_t'(1);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q      <= IDLE;
            credit_cnt_q <= credit_cnt_t'(`ICACHE_MEM_CREDITS);
            init_q       <= 1'b0;
        end
        else
        begin
            state_q      <= state_d;
            credit_cnt_q <= credit_cnt_d;
            init_q       <= init_done;
        end
    end

    // fetch address, only meaningful while busy
    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= fetch_addr;
    end

endmodule

`default_nettype wire

/* logic/icache_top.sv */
// Top of the instruction cache: controller plus tag and data stores.
// Fetch and memory ports go straight to the controller, so every timing
// of the controller holds at these ports. No logic of its own.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,

    input  wire              fetch_valid,
    input  wire fetch_addr_t fetch_addr,
    output logic             fetch_ready,
    output logic             rsp_valid,
    output word_t            rsp_data,

    input  wire              mem_credit,
    input  wire              mem_rsp_valid,
    input  wire word_t       mem_rsp_data,
    output logic             mem_req_valid,
    output fetch_addr_t      mem_req_addr
);

    logic       tag_req;
    logic       tag_write;
    tag_entry_t tag_wdata;
    tag_entry_t tag_rdata;
    set_index_t ram_addr;       // one index for both stores
    logic       data_req;
    logic       data_write;
    word_t      data_wdata;
    word_t      data_rdata;
    logic       init_done;      // tag sweep complete

    icache_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .fetch_ready   (fetch_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .init_done     (init_done),
        .tag_rdata     (tag_rdata),
        .data_rdata    (data_rdata),
        .tag_req       (tag_req),
        .tag_write     (tag_write),
        .tag_wdata     (tag_wdata),
        .ram_addr      (ram_addr),
        .data_req      (data_req),
        .data_write    (data_write),
        .data_wdata    (data_wdata),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr)
    );

    icache_tag_ram u_tag_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (tag_req),
        .write     (tag_write),
        .addr      (ram_addr),
        .wdata     (tag_wdata),
        .rdata     (tag_rdata),
        .init_done (init_done)
    );

    icache_data_ram u_data_ram (
        .clk   (clk),
        .req   (data_req),
        .write (data_write),
        .addr  (ram_addr),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

`default_nettype wire

/* verif/icache_props.sv */
// Concurrent checks on the cache controller, bound into every icache_ctrl.
// Covers credit use, the request pulse, refill forwarding, the busy window
// and quiet outputs during reset and the tag sweep.
// fail_cnt is read by the testbench for the final verdict.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_props
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              fetch_valid,
    input  wire              fetch_ready,
    input  wire              rsp_valid,
    input  wire word_t       rsp_data,
    input  wire              init_done,
    input  wire              mem_credit,
    input  wire              mem_req_valid,
    input  wire              mem_rsp_valid,
    input  wire word_t       mem_rsp_data,
    input  wire credit_cnt_t credit_cnt
);

    int fail_cnt = 0;   // failed assertions so far
    int credits_exp;    // free slots as seen on the channel, no wrap

    // +1 per pulse from memory, -1 per request sent
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            credits_exp <= `ICACHE_MEM_CREDITS;
        else
            credits_exp <= credits_exp + int'(mem_credit) - int'(mem_req_valid);
    end

    // never request on an empty credit pool
    a_req_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> (credits_exp > 0))
        else
        begin
            $error("request sent with zero credits");
            fail_cnt++;
        end

    a_credit_count: assert property (@(posedge clk) disable iff (!arst_n)
        int'(credit_cnt) == credits_exp)
        else
        begin
            $error("credit counter off the channel count");
            fail_cnt++;
        end

    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= credit_cnt_t'(`ICACHE_MEM_CREDITS))
        else
        begin
            $error("credit count above reset value");
            fail_cnt++;
        end

    // one request per miss, single cycle pulse
    a_req_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |=> !mem_req_valid)
        else
        begin
            $error("request held longer than one cycle");
            fail_cnt++;
        end

    // every memory answer reaches the core in the same cycle
    a_refill_forward: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp_valid |-> (rsp_valid && rsp_data == mem_rsp_data))
        else
        begin
            $error("refill word not forwarded");
            fail_cnt++;
        end

    a_busy_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_valid && fetch_ready) |=> !fetch_ready)
        else
        begin
            $error("ready while busy");
            fail_cnt++;
        end

    a_ready_after_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> fetch_ready)
        else
        begin
            $error("not ready after response");
            fail_cnt++;
        end

    // sweep still running, core must wait
    a_no_ready_in_sweep: assert property (@(posedge clk) disable iff (!arst_n)
        !init_done |-> !fetch_ready)
        else
        begin
            $error("ready before tag sweep done");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!fetch_ready && !rsp_valid && !mem_req_valid))
        else
        begin
            $error("outputs active in reset");
            fail_cnt++;
        end

endmodule

bind icache_ctrl icache_props u_props (
    .clk           (clk),
    .arst_n        (arst_n),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .init_done     (init_done),
    .mem_credit    (mem_credit),
    .mem_req_valid (mem_req_valid),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .credit_cnt    (credit_cnt_q)
);

`default_nettype wire

/* verif/icache_tb.sv */
// Testbench of the instruction cache top level.
// Drives fetches on falling edges, samples 5 ns before each rising edge and
// models a backing memory with random latency and credit return.
// Prints one line per test, then the totals and the verdict.
`timescale 1ns/100ps
`default_nettype none

`include "icache_config.svh"

module icache_tb
    import icache_pkg::*;
;

    localparam int LIMIT = 200;             // cycles per wait loop

    logic        clk;
    logic        arst_n;
    logic        fetch_valid;
    fetch_addr_t fetch_addr;
    logic        fetch_ready;
    logic        rsp_valid;
    word_t       rsp_data;
    logic        mem_credit;
    logic        mem_rsp_valid;
    word_t       mem_rsp_data;
    logic        mem_req_valid;
    fetch_addr_t mem_req_addr;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          req_cnt = 0;               // requests seen on the memory channel
    fetch_addr_t last_req_addr;
    logic        hold_credits = 1'b0;
    int          owed_credits = 0;
    logic        timed_out = 1'b0;

    icache_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .fetch_ready   (fetch_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // request monitor, one sample per cycle
    always
    begin
        @(negedge clk);
        #5;
        if (mem_req_valid)
        begin
            req_cnt++;
            last_req_addr = mem_req_addr;
        end
    end

    // backing memory, one request at a time like the cache
    always
    begin
        fetch_addr_t a;
        int          delay;
        logic        paid;
        @(negedge clk);
        #5;
        if (mem_req_valid)
        begin
            a = mem_req_addr;
            delay = 1 + ($urandom % 6);
            repeat (delay) @(negedge clk);
            paid = !hold_credits;           // slot freed with the answer
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = word_t'(a) ^ 32'hA5A5_0000;   // memory contents rule
            if (paid)
                mem_credit = 1'b1;
            else
                owed_credits++;
            @(negedge clk);
            mem_rsp_valid = 1'b0;
            if (paid)
                mem_credit = 1'b0;
        end
    end

    task automatic give_back_credits();
        while (owed_credits > 0)
        begin
            @(negedge clk);
            mem_credit = 1'b1;
            owed_credits--;
            @(negedge clk);
            mem_credit = 1'b0;
        end
    endtask

    // one fetch; expect_hit 1 = hit, 0 = miss, other = either
    task automatic fetch_word(input fetch_addr_t addr, input int expect_hit);
        int    wait_cnt;
        int    lat;
        int    req_before;
        word_t expect_word;
        expect_word = word_t'(addr) ^ 32'hA5A5_0000;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        #5;
        wait_cnt = 0;
        while (!fetch_ready)
        begin
            wait_cnt++;
            if (wait_cnt > LIMIT)
            begin
                $display("timeout: fetch of %h never accepted", addr);
                timed_out = 1'b1;
                fetch_valid = 1'b0;
                return;
            end
            @(negedge clk);
            #5;
        end
        req_before = req_cnt;               // accepted at the coming edge
        @(negedge clk);
        fetch_valid = 1'b0;
        #5;
        lat = 1;
        while (!rsp_valid)
        begin
            lat++;
            if (lat > LIMIT)
            begin
                $display("timeout: no response for fetch of %h", addr);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            #5;
        end
        assert (rsp_data == expect_word)
            else
            begin
                $display("ERROR rsp_data: got %h expected %h", rsp_data, expect_word);
                errors++;
            end
        if (expect_hit == 1)
        begin
            assert (lat == 1)
                else
                begin
                    $display("ERROR hit latency: got %h expected %h", lat, 1);
                    errors++;
                end
            assert (req_cnt == req_before)
                else
                begin
                    $display("ERROR mem_req_valid count: got %h expected %h",
                             req_cnt - req_before, 0);
                    errors++;
                end
        end
        else if (expect_hit == 0)
        begin
            assert (req_cnt == req_before + 1)
                else
                begin
                    $display("ERROR mem_req_valid count: got %h expected %h",
                             req_cnt - req_before, 1);
                    errors++;
                end
            assert (last_req_addr == {addr[13:2], 2'b00})
                else
                begin
                    $display("ERROR mem_req_addr: got %h expected %h",
                             last_req_addr, {addr[13:2], 2'b00});
                    errors++;
                end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "pass" : "fail");
    endtask

    initial
    begin
        int          e0;
        int          req_hold;
        fetch_addr_t a;
        fetch_addr_t b;
        void'($urandom(28));
        arst_n        = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        mem_credit    = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;

        // reset and sweep
        e0 = errors;
        repeat (5) @(negedge clk);
        assert (!fetch_ready && !rsp_valid && !mem_req_valid)
            else
            begin
                $display("ERROR reset outputs: got %h expected %h",
                         {fetch_ready, rsp_valid, mem_req_valid}, 3'h0);
                errors++;
            end
        arst_n = 1'b1;
        fetch_word(14'h1234, 0);            // cold cache, must miss
        report_test("reset and sweep", e0);

        e0 = errors;
        repeat (20)
            fetch_word(fetch_addr_t'($urandom) & 14'h3FFC, 2);
        report_test("random data", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++)
        begin
            a = fetch_addr_t'($urandom) & 14'h3FFC;
            fetch_word(a, 2);
            fetch_word(a, 1);               // now resident
        end
        report_test("hit after miss", e0);

        // same index 0x0B, tags 0x11 and 0x2A
        e0 = errors;
        a = {6'h11, 6'h0B, 2'b00};
        b = {6'h2A, 6'h0B, 2'b00};
        fetch_word(a, 2);
        fetch_word(b, 0);
        fetch_word(a, 0);
        fetch_word(b, 0);
        report_test("conflict eviction", e0);

        // three tags on set 5, the third waits for a credit
        e0 = errors;
        fetch_word({6'h01, 6'h05, 2'b00}, 2);
        hold_credits = 1'b1;
        fetch_word({6'h02, 6'h05, 2'b00}, 0);
        fetch_word({6'h03, 6'h05, 2'b00}, 0);
        fork
            fetch_word({6'h01, 6'h05, 2'b00}, 0);
            begin
                req_hold = req_cnt;
                repeat (12) @(negedge clk);
                assert (req_cnt == req_hold)
                    else
                    begin
                        $display("ERROR mem_req_valid count: got %h expected %h",
                                 req_cnt - req_hold, 0);
                        errors++;
                    end
                give_back_credits();        // memory stays silent on credits
            end
        join
        hold_credits = 1'b0;
        give_back_credits();                // slot of the last refill
        report_test("credit back-pressure", e0);

        repeat (3) @(negedge clk);
        errors += UUT.u_ctrl.u_props.fail_cnt;
        $display("tests %0d, failed %0d, check errors %0d, timeout %0d",
                 tests_run, tests_failed, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_tag_ram.sv
logic/icache_data_ram.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/icache_props.sv
verif/icache_tb.sv

/* Makefile */
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv logic/*.svh verif/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
